/* dv/pipeChecker.sv */
//##########################################################################
// Writeback checker. Matches each writeback pulse, in order, against the
// expected register and value of the stimulus file.
//##########################################################################
`timescale 1ns/1ps

module pipeChecker import pipePkg::*; #(
	parameter int dataWidth = pipePkg::dataWidth,
	parameter int maxWords  = 320
) (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    wbValid,   // writeback pulse from the DUT.
	input  logic [regAddrWidth-1:0] wbReg,     // register written.
	input  logic [dataWidth-1:0]    wbData,    // value written.
	output logic                    done,      // whole list checked.
	output logic                    timedOut,  // a pulse never came.
	output int                      errorCount // failed checks.
);

	localparam int          pulseLimit = 50;       // clocks to wait per pulse.
	localparam int          resetLimit = 64;       // clocks to wait for reset release.
	localparam int          tailCycles = 10;       // quiet clocks after the last pulse.
	localparam logic [15:0] endMark    = 16'hffff;

	logic [15:0]             stim [maxWords]; // same file as the driver.
	logic [15:0]             testNum;         // test of the current line.
	logic [regAddrWidth-1:0] expReg;          // expected destination.
	logic [dataWidth-1:0]    expVal;          // expected result.
	int                      idx;
	int                      waited;
	int                      checks;          // pulses compared in total.
	int                      testChecks;      // pulses compared in this test.
	int                      testErrors;      // errors in this test.

	// true past the last line, stops at the end marker or an empty slot.
	function automatic logic atEnd(input int at);
		return (at + 4 >= maxWords) || $isunknown(stim[at]) || (stim[at] == endMark);
	endfunction

	initial begin
		done       = 1'b0;
		timedOut   = 1'b0;
		errorCount = 0;
		checks     = 0;
		testChecks = 0;
		testErrors = 0;
		$readmemh("dv/pipeStimulus.txt", stim);

		// no writeback may show while reset is held.
		waited = 0;
		@(posedge clk);
		while (rst && waited < resetLimit) begin
			@(negedge clk);
			if (wbValid !== 1'b0) begin
				$display("writeback pulse seen during reset at %0t", $time);
				errorCount++;
			end
			@(posedge clk);
			waited++;
		end
		@(negedge clk); // outputs are sampled mid-cycle from here on.

		idx = 0;
		while (!atEnd(idx) && !timedOut) begin
			testNum = stim[idx];
			expReg  = stim[idx + 3][regAddrWidth-1:0];
			expVal  = stim[idx + 4][dataWidth-1:0];
			waited  = 0;
			while (wbValid !== 1'b1 && waited < pulseLimit) begin
				@(negedge clk);
				waited++;
			end
			if (wbValid !== 1'b1) begin
				$display("no writeback pulse for test %0d within %0d clock cycles",
				         testNum, pulseLimit);
				timedOut = 1'b1;
				errorCount++;
				testErrors++;
			end else begin
				checks++;
				testChecks++;
				if (wbReg !== expReg || wbData !== expVal) begin
					$display("mismatch at %0t: test %0d expected r%0d = %h, got r%0d = %h",
					         $time, testNum, expReg, expVal, wbReg, wbData);
					errorCount++;
					testErrors++;
				end
				@(negedge clk); // step past this pulse.
			end
			idx += 5;
			if (timedOut || atEnd(idx) || (stim[idx] != testNum)) begin
				$display("test %0d done: %0d checks, %0d errors", testNum, testChecks, testErrors);
				testChecks = 0;
				testErrors = 0;
			end
		end

		// every instruction writes once, so the line stays quiet now.
		if (!timedOut) begin
			for (int i = 0; i < tailCycles; i++) begin
				if (wbValid !== 1'b0) begin
					$display("extra writeback pulse after the last instruction at %0t", $time);
					errorCount++;
				end
				@(negedge clk);
			end
		end

		$display("summary: %0d checks, %0d errors", checks, errorCount);
		done = 1'b1;
	end

endmodule

/* dv/pipeCoreTb.sv */
//##########################################################################
// Testbench top for the pipelined execute core. Streams instructions from
// the stimulus file and gives the final verdict.
//##########################################################################
`timescale 1ns/1ps

module pipeCoreTb import pipePkg::*; ();

	localparam int          clkPeriod  = 8;        // ns.
	localparam int          rstCycles  = 10;       // reset length in clocks.
	localparam int          maxWords   = 320;      // five columns, up to 64 lines.
	localparam int          runLimit   = 2000;     // clocks allowed for the checker.
	localparam int          randomTest = 6;        // test that spaces at random.
	localparam logic [15:0] endMark    = 16'hffff; // test number of the last line.

	logic                    clk;
	logic                    rst;
	logic                    instrValid;
	instrWord                instr;
	logic                    wbValid;
	logic [regAddrWidth-1:0] wbReg;
	logic [dataWidth-1:0]    wbData;
	logic                    checkDone;  // checker has seen the whole list.
	logic                    timedOut;   // checker gave up on a pulse.
	int                      errorCount; // failed checks so far.

	logic [15:0] stim [maxWords]; // flat copy of the stimulus columns.
	integer      seed;            // state for $random.
	int          idx;             // first word of the current line.
	int          gap;             // idle cycles after the current line.
	int          waited;          // clocks spent waiting for the checker.

	//##########################################################################
	// DUT and checker
	//##########################################################################

	pipeCore #(.dataWidth(dataWidth)) dut0 (
		.clk, .rst, .instrValid, .instr,
		.wbValid, .wbReg, .wbData
	);

	pipeChecker #(.dataWidth(dataWidth), .maxWords(maxWords)) checker0 (
		.clk, .rst, .wbValid, .wbReg, .wbData,
		.done(checkDone), .timedOut, .errorCount
	);

	initial clk = 1'b0;
	always #(clkPeriod / 2) clk = ~clk; // 8 ns period.

	//##########################################################################
	// drive helpers, all changes land on the falling edge
	//##########################################################################

	task automatic issue(input logic [15:0] word);
		@(negedge clk);
		instrValid = 1'b1; // sampled at the next rising edge.
		instr      = word;
	endtask

	task automatic idle(input int n);
		for (int i = 0; i < n; i++) begin
			@(negedge clk);
			instrValid = 1'b0; // bubble.
			instr      = '0;
		end
	endtask

	//##########################################################################
	// main sequence
	//##########################################################################

	initial begin
		rst        = 1'b1;
		instrValid = 1'b0;
		instr      = '0;
		seed       = 32'hdad9_3fe0;
		$readmemh("dv/pipeStimulus.txt", stim);

		repeat (rstCycles) @(posedge clk); // ten clocks in reset.
		@(negedge clk);
		rst = 1'b0;

		idx = 0;
		while ((idx + 4 < maxWords) && !$isunknown(stim[idx]) && (stim[idx] !== endMark)) begin
			issue(stim[idx + 2]);
			if (stim[idx] == randomTest) begin
				gap = $random(seed) & 3; // zero to three idle clocks.
			end else begin
				gap = int'(stim[idx + 1]);
			end
			idle(gap);
			idx += 5; // next line.
		end
		idle(1); // make sure the strobe ends low.

		waited = 0;
		while (!checkDone && waited < runLimit) begin
			@(posedge clk);
			waited++;
		end

		if (checkDone && errorCount == 0 && !timedOut) begin
			$display("Test completed successfully");
		end else begin
			if (!checkDone) begin
				$display("checker did not finish within %0d clock cycles", runLimit);
			end
			$display("Test failed");
		end
		$finish;
	end

endmodule

/* dv/pipeStimulus.txt */
// columns, all hex: test, idle clocks after the line, instruction, expected rd, expected value
// the line with test ffff ends the list; test 6 idles at random instead
// 1 independent ops, three idle clocks apart
1 3 6112 1 0012
1 3 627f 2 007f
1 3 6385 3 ff85
1 3 6403 4 0003
1 3 0512 5 0091
1 3 1613 6 008d
1 3 2723 7 0005
1 3 3813 8 ff97
1 3 4923 9 fffa
1 3 5a14 a 0090
1 3 5b29 b fc00
1 3 7110 1 0022
1 3 73f0 3 ff75
// 2 back to back readers, EX/MEM forwarding on A, then B, then both
2 0 6c05 c 0005
2 0 0dc2 d 0084
2 0 0e4d e 0087
2 3 0fee f 010e
// 3 readers two and three instructions behind, MEM/WB and write-through
3 0 6540 5 0040
3 0 6601 6 0001
3 0 3765 7 0041
3 0 4854 8 0043
3 3 1967 9 ffc0
// 4 two writes to r10, the newer one must win
4 0 6a11 a 0011
4 0 6a22 a 0022
4 0 0baa b 0044
4 0 7a01 a 0023
4 3 0cab c 0067
// 5 writes to r0 report the value but never reach a reader
5 0 6055 0 0055
5 0 0100 1 0000
5 0 7007 0 0007
5 0 3204 2 0003
5 3 1340 3 0003
// 6 dependent chain under random spacing
6 0 6109 1 0009
6 0 7103 1 000c
6 0 0211 2 0018
6 0 5324 3 00c0
6 0 1431 4 00b4
6 0 4542 5 00ac
6 0 2653 6 0080
6 0 3761 7 008c
6 0 7780 7 000c
6 0 0875 8 00b8
ffff 0 0000 0 0000

/* list.f */
source/pipePkg.sv
source/regFile.sv
source/decodeStage.sv
source/forwardingUnit.sv
source/executeStage.sv
source/pipeCore.sv
dv/pipeChecker.sv
dv/pipeCoreTb.sv

/* source/decodeStage.sv */
//##########################################################################
// Decode stage. Splits the instruction word, reads the register file and
// loads the ID/EX latch on every valid strobe.
//##########################################################################
`timescale 1ns/1ps

module decodeStage import pipePkg::*; #(
	parameter int dataWidth = pipePkg::dataWidth
) (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    instrValid, // one instruction per strobe.
	input  instrWord                instr,      // raw word, two views.
	output logic [regAddrWidth-1:0] rdAddrA,    // to register file port A.
	output logic [regAddrWidth-1:0] rdAddrB,    // to register file port B.
	input  logic [dataWidth-1:0]    rdDataA,    // from register file port A.
	input  logic [dataWidth-1:0]    rdDataB,    // from register file port B.
	output logic                    idExValid,  // ID/EX holds an instruction.
	output opCode                   idExOp,     // latched opcode.
	output logic [regAddrWidth-1:0] idExRd,     // latched destination.
	output logic [regAddrWidth-1:0] idExRs,     // latched source A.
	output logic [regAddrWidth-1:0] idExRt,     // latched source B.
	output logic [dataWidth-1:0]    idExA,      // operand A from the file.
	output logic [dataWidth-1:0]    idExB,      // operand B from the file.
	output logic [dataWidth-1:0]    idExImm     // sign-extended immediate.
);

	//##########################################################################
	// field decode
	//##########################################################################

	opCode                   op;      // opcode, same place in both views.
	logic                    isImm;   // immediate view applies.
	logic [regAddrWidth-1:0] destReg; // rd, same place in both views.
	logic [regAddrWidth-1:0] srcRs;   // mapped first source.
	logic [regAddrWidth-1:0] srcRt;   // mapped second source.
	logic [dataWidth-1:0]    immExt;  // immediate widened to the datapath.

	assign op      = instr.r.op;
	assign destReg = instr.r.rd;
	assign isImm   = (op == opLi) || (op == opAddi);

	always_comb begin
		srcRs = instr.r.rs; // register form default.
		srcRt = instr.r.rt;
		if (isImm) begin
			srcRt = '0; // no second register source.
			if (op == opAddi) begin
				srcRs = instr.i.rd; // addi reads its own destination.
			end else begin
				srcRs = '0; // li starts from zero.
			end
		end
	end

	assign immExt = {{(dataWidth-immWidth){instr.i.imm[immWidth-1]}}, instr.i.imm};

	assign rdAddrA = srcRs; // register file read happens in this cycle.
	assign rdAddrB = srcRt;

	//##########################################################################
	// ID/EX latch
	//##########################################################################

	always_ff @(posedge clk) begin
		if (rst) begin
			idExValid <= 1'b0;
		end else begin
			idExValid <= instrValid; // bubble when no strobe.
		end
	end

	// payload only moves on a real instruction.
	always_ff @(posedge clk) begin
		if (instrValid) begin
			idExOp  <= op;
			idExRd  <= destReg;
			idExRs  <= srcRs;
			idExRt  <= srcRt;
			idExA   <= rdDataA;
			idExB   <= rdDataB;
			idExImm <= immExt;
		end
	end

endmodule

/* source/executeStage.sv */
//##########################################################################
// Execute stage. Forward muxes and ALU, then the EX/MEM and MEM/WB latches
// whose last stage drives writeback.
//##########################################################################
`timescale 1ns/1ps

module executeStage import pipePkg::*; #(
	parameter int dataWidth = pipePkg::dataWidth
) (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    idExValid,   // instruction present.
	input  opCode                   idExOp,      // operation.
	input  logic [regAddrWidth-1:0] idExRd,      // destination.
	input  logic [regAddrWidth-1:0] idExRs,      // source A, for reference.
	input  logic [regAddrWidth-1:0] idExRt,      // source B, for reference.
	input  logic [dataWidth-1:0]    idExA,       // operand A read in decode.
	input  logic [dataWidth-1:0]    idExB,       // operand B read in decode.
	input  logic [dataWidth-1:0]    idExImm,     // sign-extended immediate.
	input  fwdSel                   forwardA,    // operand A select.
	input  fwdSel                   forwardB,    // operand B select.
	output logic                    exMemValid,  // EX/MEM holds a result.
	output logic [regAddrWidth-1:0] exMemRd,     // EX/MEM destination.
	output logic [dataWidth-1:0]    exMemResult, // EX/MEM ALU result.
	output logic                    memWbValid,  // MEM/WB holds a result.
	output logic [regAddrWidth-1:0] memWbRd,     // MEM/WB destination.
	output logic [dataWidth-1:0]    memWbResult  // MEM/WB ALU result.
);

	//##########################################################################
	// operand selection
	//##########################################################################

	logic [dataWidth-1:0] fwdA;   // operand A after forwarding.
	logic [dataWidth-1:0] fwdB;   // operand B after forwarding.
	logic [dataWidth-1:0] opA;    // ALU input A.
	logic [dataWidth-1:0] opB;    // ALU input B.
	logic                 isImm;  // immediate form in ID/EX.
	logic [dataWidth-1:0] aluOut; // ALU result.

	function automatic logic [dataWidth-1:0] pickOperand(
		input fwdSel                sel,
		input logic [dataWidth-1:0] fileVal,
		input logic [dataWidth-1:0] exVal,
		input logic [dataWidth-1:0] wbVal
	);
		case (sel)
			fwdExMem: return exVal; // newest in-flight result.
			fwdMemWb: return wbVal; // one stage older.
			default:  return fileVal;
		endcase
	endfunction

	assign fwdA = pickOperand(forwardA, idExA, exMemResult, memWbResult);
	assign fwdB = pickOperand(forwardB, idExB, exMemResult, memWbResult);

	assign isImm = (idExOp == opLi) || (idExOp == opAddi);
	assign opA   = fwdA;                       // li reads r0, so zero here.
	assign opB   = isImm ? idExImm : fwdB;     // imm replaces rt.

	//##########################################################################
	// ALU
	//##########################################################################

	always_comb begin
		case (idExOp)
			opAdd:   aluOut = opA + opB;
			opSub:   aluOut = opA - opB;
			opAnd:   aluOut = opA & opB;
			opOr:    aluOut = opA | opB;
			opXor:   aluOut = opA ^ opB;
			opSll:   aluOut = opA << opB[3:0]; // shift by low four bits.
			opLi:    aluOut = opB;             // immediate passes straight.
			opAddi:  aluOut = opA + opB;       // rd plus immediate.
			default: aluOut = '0;              // unused codes write zero.
		endcase
	end

	//##########################################################################
	// EX/MEM and MEM/WB latches
	//##########################################################################

	always_ff @(posedge clk) begin
		if (rst) begin
			exMemValid <= 1'b0;
			memWbValid <= 1'b0;
		end else begin
			exMemValid <= idExValid;  // edge 2 after sampling.
			memWbValid <= exMemValid; // edge 3, writeback pulse.
		end
	end

	always_ff @(posedge clk) begin
		exMemRd     <= idExRd;
		exMemResult <= aluOut;
		memWbRd     <= exMemRd;     // no memory stage work, just a hop.
		memWbResult <= exMemResult;
	end

endmodule

/* source/forwardingUnit.sv */
//##########################################################################
// Forwarding unit. Picks the source of each ALU operand from the file,
// the EX/MEM latch or the MEM/WB latch; the newest result wins.
//##########################################################################
`timescale 1ns/1ps

module forwardingUnit import pipePkg::*; (
	input  logic [regAddrWidth-1:0] exMemRd,    // destination in EX/MEM.
	input  logic [regAddrWidth-1:0] memWbRd,    // destination in MEM/WB.
	input  logic [regAddrWidth-1:0] idExRs,     // source A in ID/EX.
	input  logic [regAddrWidth-1:0] idExRt,     // source B in ID/EX.
	input  logic                    exMemValid, // EX/MEM will write.
	input  logic                    memWbValid, // MEM/WB will write.
	output fwdSel                   forwardA,   // operand A select.
	output fwdSel                   forwardB    // operand B select.
);

	logic exLive;    // EX/MEM result may be forwarded.
	logic wbLive;    // MEM/WB result may be forwarded.
	logic exHazardA; // EX hazard on operand A.
	logic exHazardB; // EX hazard on operand B.
	logic wbHazardA; // MEM hazard on operand A.
	logic wbHazardB; // MEM hazard on operand B.

	// r0 is a constant, so a write to it never forwards.
	assign exLive = exMemValid && (exMemRd != '0);
	assign wbLive = memWbValid && (memWbRd != '0);

	assign exHazardA = exLive && (exMemRd == idExRs);
	assign exHazardB = exLive && (exMemRd == idExRt);

	// MEM hazard only when the newer EX/MEM value does not match.
	assign wbHazardA = wbLive && !exHazardA && (memWbRd == idExRs);
	assign wbHazardB = wbLive && !exHazardB && (memWbRd == idExRt);

	assign forwardA = exHazardA ? fwdExMem :
	                  wbHazardA ? fwdMemWb :
	                              fwdNone;

	assign forwardB = exHazardB ? fwdExMem :
	                  wbHazardB ? fwdMemWb :
	                              fwdNone;

endmodule

/* source/pipeCore.sv */
//##########################################################################
// Core top level. Wires decode, forwarding, execute and the register file
// and reports each writeback on a one-cycle pulse.
//##########################################################################
`timescale 1ns/1ps

module pipeCore import pipePkg::*; #(
	parameter int dataWidth = pipePkg::dataWidth
) (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    instrValid, // instruction strobe.
	input  instrWord                instr,      // instruction word.
	output logic                    wbValid,    // writeback pulse.
	output logic [regAddrWidth-1:0] wbReg,      // register written.
	output logic [dataWidth-1:0]    wbData      // value written.
);

	//##########################################################################
	// interconnect
	//##########################################################################

	logic [regAddrWidth-1:0] rdAddrA, rdAddrB; // decode to file.
	logic [dataWidth-1:0]    rdDataA, rdDataB; // file to decode.

	logic                    idExValid;
	opCode                   idExOp;
	logic [regAddrWidth-1:0] idExRd, idExRs, idExRt;
	logic [dataWidth-1:0]    idExA, idExB, idExImm;

	fwdSel                   forwardA, forwardB; // operand selects.

	logic                    exMemValid, memWbValid;
	logic [regAddrWidth-1:0] exMemRd, memWbRd;
	logic [dataWidth-1:0]    exMemResult, memWbResult;

	assign wbValid = memWbValid; // MEM/WB is the writeback stage.
	assign wbReg   = memWbRd;
	assign wbData  = memWbResult;

	//##########################################################################
	// stages
	//##########################################################################

	regFile #(.dataWidth(dataWidth)) regFile0 (
		.clk, .rst,
		.rdAddrA, .rdAddrB, .rdDataA, .rdDataB,
		.wrEn(memWbValid), .wrAddr(memWbRd), .wrData(memWbResult) // lands at edge 4.
	);

	decodeStage #(.dataWidth(dataWidth)) decode0 (
		.clk, .rst, .instrValid, .instr,
		.rdAddrA, .rdAddrB, .rdDataA, .rdDataB,
		.idExValid, .idExOp, .idExRd, .idExRs, .idExRt,
		.idExA, .idExB, .idExImm
	);

	forwardingUnit fwd0 (
		.exMemRd, .memWbRd, .idExRs, .idExRt,
		.exMemValid, .memWbValid,
		.forwardA, .forwardB
	);

	executeStage #(.dataWidth(dataWidth)) execute0 (
		.clk, .rst,
		.idExValid, .idExOp, .idExRd, .idExRs, .idExRt,
		.idExA, .idExB, .idExImm,
		.forwardA, .forwardB,
		.exMemValid, .exMemRd, .exMemResult,
		.memWbValid, .memWbRd, .memWbResult
	);

endmodule

/* source/pipePkg.sv */
//##########################################################################
// Shared types and widths for the pipelined execute core. Holds the
// instruction union, the opcode set and the operand forward selects.
//##########################################################################

package pipePkg;

	//##########################################################################
	// widths
	//##########################################################################

	parameter int dataWidth    = 16; // register and ALU width.
	parameter int regAddrWidth = 4;  // sixteen registers.
	parameter int numRegs      = 16; // register file depth.
	parameter int immWidth     = 8;  // immediate field of the I-form.

	//##########################################################################
	// opcodes
	//##########################################################################

	typedef enum logic [3:0] {
		opAdd  = 4'h0, // rd = rs + rt.
		opSub  = 4'h1, // rd = rs - rt.
		opAnd  = 4'h2, // rd = rs & rt.
		opOr   = 4'h3, // rd = rs | rt.
		opXor  = 4'h4, // rd = rs ^ rt.
		opSll  = 4'h5, // rd = rs << rt[3:0].
		opLi   = 4'h6, // rd = sext(imm).
		opAddi = 4'h7  // rd = rd + sext(imm).
	} opCode;

	//##########################################################################
	// instruction word, one 16-bit word with two decodings
	//##########################################################################

	// register form, three register fields.
	typedef struct packed {
		opCode                   op; // operation.
		logic [regAddrWidth-1:0] rd; // destination.
		logic [regAddrWidth-1:0] rs; // first source.
		logic [regAddrWidth-1:0] rt; // second source.
	} regForm;

	// immediate form, imm takes the place of rs and rt.
	typedef struct packed {
		opCode                   op;  // operation.
		logic [regAddrWidth-1:0] rd;  // destination, also the source for addi.
		logic [immWidth-1:0]     imm; // signed immediate.
	} immForm;

	typedef union packed {
		regForm r; // register view.
		immForm i; // immediate view.
	} instrWord;

	//##########################################################################
	// forward selects for the ALU operand muxes
	//##########################################################################

	typedef enum logic [1:0] {
		fwdNone  = 2'b00, // value read in decode.
		fwdMemWb = 2'b01, // result sitting in MEM/WB.
		fwdExMem = 2'b10  // result sitting in EX/MEM, newest.
	} fwdSel;

endpackage

/* source/regFile.sv */
//##########################################################################
// Register file, sixteen entries with two read ports and one write port.
// Register 0 reads zero; reads see a write of the same cycle.
//##########################################################################
`timescale 1ns/1ps

module regFile import pipePkg::*; #(
	parameter int dataWidth = pipePkg::dataWidth
) (
	input  logic                    clk,
	input  logic                    rst,
	input  logic [regAddrWidth-1:0] rdAddrA, // read port A address.
	input  logic [regAddrWidth-1:0] rdAddrB, // read port B address.
	output logic [dataWidth-1:0]    rdDataA, // read port A data.
	output logic [dataWidth-1:0]    rdDataB, // read port B data.
	input  logic                    wrEn,    // write strobe from writeback.
	input  logic [regAddrWidth-1:0] wrAddr,  // write address.
	input  logic [dataWidth-1:0]    wrData   // write data.
);

	logic [dataWidth-1:0] regs [numRegs]; // storage array.
	logic                 wrLive;         // write that actually lands.

	assign wrLive = wrEn && (wrAddr != '0); // r0 never takes a write.

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < numRegs; i++) begin
				regs[i] <= '0; // every register reads zero after reset.
			end
		end else if (wrLive) begin
			regs[wrAddr] <= wrData;
		end
	end

	// write-through covers the reader three instructions behind the writer.
	assign rdDataA = (rdAddrA == '0)                 ? '0     : // hard zero.
	                 (wrLive && (wrAddr == rdAddrA)) ? wrData : // bypass.
	                                                   regs[rdAddrA];
	assign rdDataB = (rdAddrB == '0)                 ? '0     : // hard zero.
	                 (wrLive && (wrAddr == rdAddrB)) ? wrData : // bypass.
	                                                   regs[rdAddrB];

endmodule
